/* net_msg_pkg.sv */
// network message formats for the ring; src and dest are 3 bits wide,
// so a ring holds at most 8 routers
package net_msg_pkg;

  // field widths
  localparam int c_srcdest_nbits  = 3;
  localparam int c_opaque_nbits   = 3;
  localparam int c_payload_cnbits = 32;
  localparam int c_data_nbits     = 32;

  // --------------------
  // header and data word
  // --------------------

  // dest sits in the top bits, control payload in the bottom bits
  typedef struct packed {
    logic [c_srcdest_nbits-1:0]  dest;
    logic [c_srcdest_nbits-1:0]  src;
    logic [c_opaque_nbits-1:0]   opaque;
    logic [c_payload_cnbits-1:0] payload;
  } net_hdr_t;

  // data word, queued apart from the header
  typedef logic [c_data_nbits-1:0] net_data_t;

endpackage

/* router_pkg.sv */
// router structure: three ports in the order prev, term, next
// the select type covers port indices 0 to 2 only
package router_pkg;

  localparam int c_num_ports = 3;

  // --------------------
  // port indices
  // --------------------
  localparam int c_port_prev = 0;
  localparam int c_port_term = 1;
  localparam int c_port_next = 2;

  // one bit per port, one-hot or zero
  typedef logic [c_num_ports-1:0] port_req_t;

  // input port index that feeds an output column of the crossbar
  typedef logic [1:0] xbar_sel_t;

endpackage

/* msg_queue.sv */
// normal val/rdy queue, no bypass: an entry shows at the head one cycle
// after enqueue; enq_rdy is low while full
`timescale 1ns/100ps

module msg_queue #(
  parameter type p_msg_t = logic [31:0],
  parameter int  p_depth = 2
) (
  input  logic   clk,
  input  logic   arst_n,

  input  logic   enq_val,
  output logic   enq_rdy,
  input  p_msg_t enq_msg,

  output logic   deq_val,
  input  logic   deq_rdy,
  output p_msg_t deq_msg
);

  localparam int c_ptr_nbits = (p_depth > 1) ? $clog2(p_depth) : 1;
  localparam int c_cnt_nbits = $clog2(p_depth + 1);

  p_msg_t                 mem [p_depth];
  logic [c_ptr_nbits-1:0] wr_ptr;
  logic [c_ptr_nbits-1:0] rd_ptr;
  logic [c_cnt_nbits-1:0] count;
  logic                   do_enq;
  logic                   do_deq;

  assign enq_rdy = (count != c_cnt_nbits'(p_depth));
  assign deq_val = (count != '0);
  assign deq_msg = mem[rd_ptr];

  assign do_enq = enq_val && enq_rdy;
  assign do_deq = deq_val && deq_rdy;

  // storage
  always_ff @(posedge clk) begin
    if (do_enq) begin
      mem[wr_ptr] <= enq_msg;
    end
  end

  // pointers wrap at p_depth, so any depth works
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr <= (wr_ptr == c_ptr_nbits'(p_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_deq) begin
        rd_ptr <= (rd_ptr == c_ptr_nbits'(p_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_enq, do_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* input_port.sv */
// one router input: header and data queues filled and drained together
// dest is assumed below p_num_routers, p_num_routers from 2 to 8
`timescale 1ns/100ps

module input_port #(
  parameter int p_router_id   = 0,
  parameter int p_num_routers = 8,
  parameter int p_queue_depth = 2
) (
  input  logic                   clk,
  input  logic                   arst_n,

  input  logic                   in_val,
  output logic                   in_rdy,
  input  net_msg_pkg::net_hdr_t  in_hdr,
  input  net_msg_pkg::net_data_t in_data,

  output net_msg_pkg::net_hdr_t  head_hdr,
  output net_msg_pkg::net_data_t head_data,
  output router_pkg::port_req_t  req,
  input  router_pkg::port_req_t  grant
);

  logic       hdr_enq_rdy;
  logic       data_enq_rdy;
  logic       hdr_deq_val;
  logic       data_deq_val;
  logic       head_val;
  logic       enq;
  logic       deq;
  logic [4:0] fwd_dist;

  assign in_rdy   = hdr_enq_rdy && data_enq_rdy;
  assign enq      = in_val && in_rdy;
  assign head_val = hdr_deq_val && data_deq_val;
  // a grant is only given with out_rdy high, so it always means a transfer
  assign deq      = |grant;

  // --------------------
  // queues
  // --------------------

  msg_queue #(
    .p_msg_t (net_msg_pkg::net_hdr_t),
    .p_depth (p_queue_depth)
  ) u_hdr_queue (
    .clk     (clk),
    .arst_n  (arst_n),
    .enq_val (enq),
    .enq_rdy (hdr_enq_rdy),
    .enq_msg (in_hdr),
    .deq_val (hdr_deq_val),
    .deq_rdy (deq),
    .deq_msg (head_hdr)
  );

  msg_queue #(
    .p_msg_t (net_msg_pkg::net_data_t),
    .p_depth (p_queue_depth)
  ) u_data_queue (
    .clk     (clk),
    .arst_n  (arst_n),
    .enq_val (enq),
    .enq_rdy (data_enq_rdy),
    .enq_msg (in_data),
    .deq_val (data_deq_val),
    .deq_rdy (deq),
    .deq_msg (head_data)
  );

  // --------------------
  // route computation
  // --------------------

  // forward distance = (dest - router id) mod ring size
  always_comb begin
    fwd_dist = 5'(head_hdr.dest) + 5'(p_num_routers) - 5'(p_router_id);
    if (fwd_dist >= 5'(p_num_routers)) begin
      fwd_dist = fwd_dist - 5'(p_num_routers);
    end
  end

  // ties at half the ring go east
  always_comb begin
    req = '0;
    if (head_val) begin
      if (fwd_dist == 5'd0) begin
        req[router_pkg::c_port_term] = 1'b1;
      end else if (fwd_dist <= 5'(p_num_routers / 2)) begin
        req[router_pkg::c_port_next] = 1'b1;
      end else begin
        req[router_pkg::c_port_prev] = 1'b1;
      end
    end
  end

endmodule

/* output_arbiter.sv */
// round-robin arbiter for one output port
// grants only while out_rdy is high, so a grant is always a transfer
`timescale 1ns/100ps

module output_arbiter (
  input  logic                  clk,
  input  logic                  arst_n,

  input  router_pkg::port_req_t reqs,
  output router_pkg::port_req_t grants,

  output logic                  out_val,
  input  logic                  out_rdy,
  output router_pkg::xbar_sel_t xbar_sel
);

  router_pkg::xbar_sel_t ptr;
  router_pkg::xbar_sel_t winner;
  logic                  found;
  logic                  xfer;

  // --------------------
  // winner search
  // --------------------

  // priority starts at ptr and wraps around the ports
  always_comb begin
    int idx;
    winner = ptr;
    found  = 1'b0;
    for (int i = 0; i < router_pkg::c_num_ports; i++) begin
      idx = int'(ptr) + i;
      if (idx >= router_pkg::c_num_ports) begin
        idx = idx - router_pkg::c_num_ports;
      end
      if (!found && reqs[idx]) begin
        found  = 1'b1;
        winner = router_pkg::xbar_sel_t'(idx);
      end
    end
  end

  assign out_val  = |reqs;
  assign xbar_sel = winner;
  assign xfer     = found && out_rdy;

  always_comb begin
    grants = '0;
    if (xfer) begin
      grants[winner] = 1'b1;
    end
  end

  // --------------------
  // pointer
  // --------------------

  // next search starts just after the last winner
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr <= '0;
    end else if (xfer) begin
      if (winner == router_pkg::xbar_sel_t'(router_pkg::c_num_ports - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= winner + 2'd1;
      end
    end
  end

endmodule

/* crossbar.sv */
// three-by-three crossbar, each output picks one input on its own
// a select of 3 falls through to input 2
`timescale 1ns/100ps

module crossbar #(
  parameter type p_msg_t = logic [31:0]
) (
  input  p_msg_t                in0,
  input  p_msg_t                in1,
  input  p_msg_t                in2,
  input  router_pkg::xbar_sel_t sel0,
  input  router_pkg::xbar_sel_t sel1,
  input  router_pkg::xbar_sel_t sel2,
  output p_msg_t                out0,
  output p_msg_t                out1,
  output p_msg_t                out2
);

  function automatic p_msg_t pick(input router_pkg::xbar_sel_t sel);
    case (sel)
      2'd0:    return in0;
      2'd1:    return in1;
      default: return in2;
    endcase
  endfunction

  assign out0 = pick(sel0);
  assign out1 = pick(sel1);
  assign out2 = pick(sel2);

endmodule

/* ring_router.sv */
// three-port ring router: port 0 from the west, 1 terminal, 2 to the east
// deterministic shortest-path routing, no adaptive choice
`timescale 1ns/100ps

module ring_router #(
  parameter int p_router_id   = 0,
  parameter int p_num_routers = 8,
  parameter int p_queue_depth = 2
) (
  input  logic                   clk,
  input  logic                   arst_n,

  input  logic                   in0_val,
  output logic                   in0_rdy,
  input  net_msg_pkg::net_hdr_t  in0_hdr,
  input  net_msg_pkg::net_data_t in0_data,

  input  logic                   in1_val,
  output logic                   in1_rdy,
  input  net_msg_pkg::net_hdr_t  in1_hdr,
  input  net_msg_pkg::net_data_t in1_data,

  input  logic                   in2_val,
  output logic                   in2_rdy,
  input  net_msg_pkg::net_hdr_t  in2_hdr,
  input  net_msg_pkg::net_data_t in2_data,

  output logic                   out0_val,
  input  logic                   out0_rdy,
  output net_msg_pkg::net_hdr_t  out0_hdr,
  output net_msg_pkg::net_data_t out0_data,

  output logic                   out1_val,
  input  logic                   out1_rdy,
  output net_msg_pkg::net_hdr_t  out1_hdr,
  output net_msg_pkg::net_data_t out1_data,

  output logic                   out2_val,
  input  logic                   out2_rdy,
  output net_msg_pkg::net_hdr_t  out2_hdr,
  output net_msg_pkg::net_data_t out2_data
);

  net_msg_pkg::net_hdr_t  in0_head_hdr;
  net_msg_pkg::net_hdr_t  in1_head_hdr;
  net_msg_pkg::net_hdr_t  in2_head_hdr;
  net_msg_pkg::net_data_t in0_head_data;
  net_msg_pkg::net_data_t in1_head_data;
  net_msg_pkg::net_data_t in2_head_data;

  router_pkg::port_req_t  in0_req;
  router_pkg::port_req_t  in1_req;
  router_pkg::port_req_t  in2_req;
  router_pkg::port_req_t  in0_grant;
  router_pkg::port_req_t  in1_grant;
  router_pkg::port_req_t  in2_grant;

  router_pkg::port_req_t  out0_reqs;
  router_pkg::port_req_t  out1_reqs;
  router_pkg::port_req_t  out2_reqs;
  router_pkg::port_req_t  out0_grants;
  router_pkg::port_req_t  out1_grants;
  router_pkg::port_req_t  out2_grants;

  router_pkg::xbar_sel_t  xbar_sel0;
  router_pkg::xbar_sel_t  xbar_sel1;
  router_pkg::xbar_sel_t  xbar_sel2;

  // --------------------
  // request and grant transposition
  // --------------------

  // bit i of an output's vector belongs to input i
  assign out0_reqs = {in2_req[0], in1_req[0], in0_req[0]};
  assign out1_reqs = {in2_req[1], in1_req[1], in0_req[1]};
  assign out2_reqs = {in2_req[2], in1_req[2], in0_req[2]};

  assign in0_grant = {out2_grants[0], out1_grants[0], out0_grants[0]};
  assign in1_grant = {out2_grants[1], out1_grants[1], out0_grants[1]};
  assign in2_grant = {out2_grants[2], out1_grants[2], out0_grants[2]};

  // --------------------
  // input ports
  // --------------------

  input_port #(
    .p_router_id   (p_router_id),
    .p_num_routers (p_num_routers),
    .p_queue_depth (p_queue_depth)
  ) u_in0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_val    (in0_val),
    .in_rdy    (in0_rdy),
    .in_hdr    (in0_hdr),
    .in_data   (in0_data),
    .head_hdr  (in0_head_hdr),
    .head_data (in0_head_data),
    .req       (in0_req),
    .grant     (in0_grant)
  );

  input_port #(
    .p_router_id   (p_router_id),
    .p_num_routers (p_num_routers),
    .p_queue_depth (p_queue_depth)
  ) u_in1 (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_val    (in1_val),
    .in_rdy    (in1_rdy),
    .in_hdr    (in1_hdr),
    .in_data   (in1_data),
    .head_hdr  (in1_head_hdr),
    .head_data (in1_head_data),
    .req       (in1_req),
    .grant     (in1_grant)
  );

  input_port #(
    .p_router_id   (p_router_id),
    .p_num_routers (p_num_routers),
    .p_queue_depth (p_queue_depth)
  ) u_in2 (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_val    (in2_val),
    .in_rdy    (in2_rdy),
    .in_hdr    (in2_hdr),
    .in_data   (in2_data),
    .head_hdr  (in2_head_hdr),
    .head_data (in2_head_data),
    .req       (in2_req),
    .grant     (in2_grant)
  );

  // --------------------
  // output arbiters
  // --------------------

  output_arbiter u_arb0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .reqs     (out0_reqs),
    .grants   (out0_grants),
    .out_val  (out0_val),
    .out_rdy  (out0_rdy),
    .xbar_sel (xbar_sel0)
  );

  output_arbiter u_arb1 (
    .clk      (clk),
    .arst_n   (arst_n),
    .reqs     (out1_reqs),
    .grants   (out1_grants),
    .out_val  (out1_val),
    .out_rdy  (out1_rdy),
    .xbar_sel (xbar_sel1)
  );

  output_arbiter u_arb2 (
    .clk      (clk),
    .arst_n   (arst_n),
    .reqs     (out2_reqs),
    .grants   (out2_grants),
    .out_val  (out2_val),
    .out_rdy  (out2_rdy),
    .xbar_sel (xbar_sel2)
  );

  // --------------------
  // crossbars
  // --------------------

  // header and data share the selects, so they leave together
  crossbar #(
    .p_msg_t (net_msg_pkg::net_hdr_t)
  ) u_xbar_hdr (
    .in0  (in0_head_hdr),
    .in1  (in1_head_hdr),
    .in2  (in2_head_hdr),
    .sel0 (xbar_sel0),
    .sel1 (xbar_sel1),
    .sel2 (xbar_sel2),
    .out0 (out0_hdr),
    .out1 (out1_hdr),
    .out2 (out2_hdr)
  );

  crossbar #(
    .p_msg_t (net_msg_pkg::net_data_t)
  ) u_xbar_data (
    .in0  (in0_head_data),
    .in1  (in1_head_data),
    .in2  (in2_head_data),
    .sel0 (xbar_sel0),
    .sel1 (xbar_sel1),
    .sel2 (xbar_sel2),
    .out0 (out0_data),
    .out1 (out1_data),
    .out2 (out2_data)
  );

endmodule

/* tb_ring_router.sv */
// self-checking testbench for router 2 of an 8-router ring, queue depth 2
// a model of each input's queues predicts in_rdy, out_val and every delivery
`timescale 1ns/100ps

module tb_ring_router;

  localparam int c_router_id    = 2;
  localparam int c_num_routers  = 8;
  localparam int c_queue_depth  = 2;
  localparam int c_ports        = router_pkg::c_num_ports;
  localparam int c_reset_cycles = 4;
  localparam int c_num_rows     = 23;
  localparam int c_pat_len      = 1024;

  typedef struct packed {
    int port;
    int dest;
    int opaque;
    int stall;
  } row_t;

  // input port, dest, opaque, out_rdy stall cycles on the routed output
  row_t rows [c_num_rows] = '{
    '{0, 2, 1, 0}, '{0, 3, 2, 0}, '{0, 6, 3, 0}, '{0, 7, 4, 0},
    '{0, 1, 5, 0}, '{1, 2, 6, 0}, '{1, 4, 7, 0}, '{1, 5, 6, 0},
    '{1, 0, 0, 0}, '{2, 2, 1, 0}, '{2, 5, 2, 0}, '{2, 7, 3, 0},
    '{2, 0, 4, 0}, '{2, 1, 5, 0},
    // back-pressure on the east output
    '{0, 5, 0, 25}, '{0, 4, 1, 0}, '{0, 6, 2, 0},
    // all inputs contend for the terminal
    '{0, 2, 3, 30}, '{1, 2, 4, 0}, '{2, 2, 5, 0},
    '{0, 2, 6, 0}, '{1, 2, 7, 0}, '{2, 2, 0, 0}
  };

  logic                   clk;
  logic                   arst_n;
  logic                   in_val   [c_ports];
  logic                   in_rdy   [c_ports];
  net_msg_pkg::net_hdr_t  in_hdr   [c_ports];
  net_msg_pkg::net_data_t in_data  [c_ports];
  logic                   out_val  [c_ports];
  logic                   out_rdy  [c_ports];
  net_msg_pkg::net_hdr_t  out_hdr  [c_ports];
  net_msg_pkg::net_data_t out_data [c_ports];

  // model of the messages waiting in each input
  net_msg_pkg::net_hdr_t  hdr_q  [c_ports][$];
  net_msg_pkg::net_data_t data_q [c_ports][$];
  int                     port_q [c_ports][$];

  int seed = 59;
  int cycle = 0;
  int stall_until [c_ports] = '{0, 0, 0};
  int last_src [c_ports] = '{-1, -1, -1};
  bit rdy_pat [c_ports][c_pat_len];
  int n_checks = 0;
  int n_mismatch = 0;
  int n_other = 0;
  int n_delivered = 0;

  ring_router #(
    .p_router_id   (c_router_id),
    .p_num_routers (c_num_routers),
    .p_queue_depth (c_queue_depth)
  ) u_ring_router (
    .clk       (clk),
    .arst_n    (arst_n),
    .in0_val   (in_val[0]),
    .in0_rdy   (in_rdy[0]),
    .in0_hdr   (in_hdr[0]),
    .in0_data  (in_data[0]),
    .in1_val   (in_val[1]),
    .in1_rdy   (in_rdy[1]),
    .in1_hdr   (in_hdr[1]),
    .in1_data  (in_data[1]),
    .in2_val   (in_val[2]),
    .in2_rdy   (in_rdy[2]),
    .in2_hdr   (in_hdr[2]),
    .in2_data  (in_data[2]),
    .out0_val  (out_val[0]),
    .out0_rdy  (out_rdy[0]),
    .out0_hdr  (out_hdr[0]),
    .out0_data (out_data[0]),
    .out1_val  (out_val[1]),
    .out1_rdy  (out_rdy[1]),
    .out1_hdr  (out_hdr[1]),
    .out1_data (out_data[1]),
    .out2_val  (out_val[2]),
    .out2_rdy  (out_rdy[2]),
    .out2_hdr  (out_hdr[2]),
    .out2_data (out_data[2])
  );

  // --------------------
  // model helpers and compare tasks
  // --------------------

  // forward distance rule: 0 to the terminal, up to half the ring east, else west
  function automatic int route(logic [2:0] dest);
    int d;
    d = (int'(dest) + c_num_routers - c_router_id) % c_num_routers;
    if (d == 0) begin
      return router_pkg::c_port_term;
    end else if (d <= c_num_routers / 2) begin
      return router_pkg::c_port_next;
    end
    return router_pkg::c_port_prev;
  endfunction

  function automatic bit requests(int i, int o);
    return (port_q[i].size() != 0) && (port_q[i][0] == o);
  endfunction

  function automatic bit model_empty();
    return (hdr_q[0].size() == 0) && (hdr_q[1].size() == 0) && (hdr_q[2].size() == 0);
  endfunction

  task automatic check_hdr(string name, net_msg_pkg::net_hdr_t got,
                           net_msg_pkg::net_hdr_t exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_data(string name, net_msg_pkg::net_data_t got,
                            net_msg_pkg::net_data_t exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // --------------------
  // clock, out_rdy and watchdog
  // --------------------

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // random ready pattern, forced low while a row asks for a stall
  initial begin
    for (int o = 0; o < c_ports; o++) begin
      out_rdy[o] <= 1'b1;
    end
    forever begin
      @(posedge clk);
      cycle = cycle + 1;
      for (int o = 0; o < c_ports; o++) begin
        if (cycle < stall_until[o]) begin
          out_rdy[o] <= 1'b0;
        end else begin
          out_rdy[o] <= rdy_pat[o][cycle % c_pat_len];
        end
      end
    end
  end

  initial begin
    repeat ((c_num_rows * 60) + c_reset_cycles) @(posedge clk);
    $display("error: run timed out with messages still waiting");
    $display("checks %0d, mismatches %0d, other errors %0d, delivered %0d of %0d",
             n_checks, n_mismatch, n_other, n_delivered, c_num_rows);
    $display("Checks failed");
    $finish;
  end

  // --------------------
  // monitor
  // --------------------

  // sampled at the falling edge, where inputs and outputs are settled
  always @(negedge clk) begin
    int n_req;
    int only;
    int s;
    for (int i = 0; i < c_ports; i++) begin
      check_bit($sformatf("in%0d_rdy", i), in_rdy[i], hdr_q[i].size() < c_queue_depth);
    end
    for (int o = 0; o < c_ports; o++) begin
      n_req = 0;
      only  = 0;
      for (int i = 0; i < c_ports; i++) begin
        if (requests(i, o)) begin
          n_req++;
          only = i;
        end
      end
      check_bit($sformatf("out%0d_val", o), out_val[o], n_req != 0);
      // a single requester must be the one shown, stalled or not
      if (n_req == 1) begin
        check_hdr($sformatf("out%0d_hdr", o), out_hdr[o], hdr_q[only][0]);
        check_data($sformatf("out%0d_data", o), out_data[o], data_q[only][0]);
      end
    end
    for (int o = 0; o < c_ports; o++) begin
      if (out_val[o] && out_rdy[o]) begin
        s = int'(out_hdr[o].src);
        if (s >= c_ports || hdr_q[s].size() == 0) begin
          n_other++;
          $display("error at %0t: output %0d sent a message no input holds", $time, o);
        end else begin
          if (port_q[s][0] != o) begin
            n_other++;
            $display("error at %0t: message from input %0d left on output %0d, not %0d",
                     $time, s, o, port_q[s][0]);
          end
          if (last_src[o] == s) begin
            for (int t = 0; t < c_ports; t++) begin
              if (t != s && requests(t, o)) begin
                n_other++;
                $display("error at %0t: output %0d served input %0d twice while input %0d waited",
                         $time, o, s, t);
              end
            end
          end
          check_hdr($sformatf("out%0d_hdr", o), out_hdr[o], hdr_q[s][0]);
          check_data($sformatf("out%0d_data", o), out_data[o], data_q[s][0]);
          void'(hdr_q[s].pop_front());
          void'(data_q[s].pop_front());
          void'(port_q[s].pop_front());
          last_src[o] = s;
          n_delivered++;
        end
      end
    end
    for (int i = 0; i < c_ports; i++) begin
      if (in_val[i] && in_rdy[i]) begin
        hdr_q[i].push_back(in_hdr[i]);
        data_q[i].push_back(in_data[i]);
        port_q[i].push_back(route(in_hdr[i].dest));
      end
    end
  end

  // --------------------
  // stimulus
  // --------------------

  initial begin
    net_msg_pkg::net_hdr_t  hdr;
    net_msg_pkg::net_data_t data;
    int                     p;
    arst_n <= 1'b0;
    for (int i = 0; i < c_ports; i++) begin
      in_val[i]  <= 1'b0;
      in_hdr[i]  <= '0;
      in_data[i] <= '0;
    end
    for (int o = 0; o < c_ports; o++) begin
      for (int k = 0; k < c_pat_len; k++) begin
        rdy_pat[o][k] = (($random(seed) & 3) != 0);
      end
    end
    repeat (c_reset_cycles) @(posedge clk);
    arst_n <= 1'b1;

    for (int r = 0; r < c_num_rows; r++) begin
      p = rows[r].port;
      @(negedge clk);
      hdr.dest        = 3'(rows[r].dest);
      hdr.src         = 3'(p);
      hdr.opaque      = 3'(rows[r].opaque);
      hdr.payload     = $random(seed);
      data            = $random(seed);
      if (rows[r].stall != 0) begin
        stall_until[route(3'(rows[r].dest))] = cycle + 1 + rows[r].stall;
      end
      @(posedge clk);
      in_hdr[p]  <= hdr;
      in_data[p] <= data;
      in_val[p]  <= 1'b1;
      // hold until the router takes it
      @(negedge clk);
      while (!in_rdy[p]) begin
        @(negedge clk);
      end
      @(posedge clk);
      in_val[p] <= 1'b0;
    end

    @(negedge clk);
    while (!model_empty()) begin
      @(negedge clk);
    end
    repeat (2) @(posedge clk);
    $display("checks %0d, mismatches %0d, other errors %0d, delivered %0d of %0d",
             n_checks, n_mismatch, n_other, n_delivered, c_num_rows);
    if (n_mismatch == 0 && n_other == 0 && n_delivered == c_num_rows) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* project.f */
net_msg_pkg.sv
router_pkg.sv
msg_queue.sv
input_port.sv
output_arbiter.sv
crossbar.sv
ring_router.sv
tb_ring_router.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the ring router testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_ring_router -f project.f
result=$(./obj_dir/Vtb_ring_router)
echo "$result"

if grep -qx "All checks passed" <<< "$result"; then
  exit 0
fi
exit 1
